// File: rtl/saa_params.svh
`ifndef SAA_PARAMS_SVH
`define SAA_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// register map, 5-bit addresses
////////////////////////////////////////////////////////////////////////////

// six amplitude registers from here, one per channel
`define SAA_ADDR_AMP0       5'h00
// six frequency registers, stored as 510 - din
`define SAA_ADDR_FREQ0      5'h08
// three octave registers, two channels each
`define SAA_ADDR_OCT0       5'h10
`define SAA_ADDR_TONE_EN    5'h14
`define SAA_ADDR_NOISE_EN   5'h15
`define SAA_ADDR_NOISE_SEL  5'h16
// two envelope registers, only bit 7 kept
`define SAA_ADDR_ENV0       5'h18
`define SAA_ADDR_CTRL       5'h1C

// noise source
`define SAA_LFSR_SEED       31'h1111_1111
`define SAA_NOISE_PERIOD0   256
`define SAA_NOISE_PERIOD1   512
`define SAA_NOISE_PERIOD2   1024

`endif

// File: rtl/saa_pkg.sv
package saa_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // register view handed to a voice group
    ////////////////////////////////////////////////////////////////////////////

    // one tone channel, 21 bits
    typedef struct packed {
        // low nibble left, high nibble right
        logic [7:0] amp;
        // frequency count, already converted
        logic [8:0] freq;
        logic [2:0] octave;
        logic       tone_en;
    } tone_ctrl_t;

    // one group of three channels plus its noise source, 69 bits
    typedef struct packed {
        tone_ctrl_t [2:0] chan;
        logic [2:0]       noise_en;
        // 0-2 fixed rate, 3 clocked by channel 0
        logic [1:0]       noise_sel;
        // envelope bit 7, takes the middle tone off the mix
        logic             env_tone_off;
    } group_regs_t;

    ////////////////////////////////////////////////////////////////////////////
    // levels handed to the output mixer
    ////////////////////////////////////////////////////////////////////////////

    // tone plus noise, so up to twice a nibble
    typedef struct packed {
        logic [4:0] left;
        logic [4:0] right;
    } chan_level_t;

    // three channels of a group, 30 bits
    typedef chan_level_t [2:0] group_levels_t;

endpackage

// File: rtl/saa_reg_file.sv
`include "saa_params.svh"

module saa_reg_file import saa_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        cs_n,
    input  logic        a0,
    input  logic        wr_n,
    input  logic [7:0]  din,
    output group_regs_t grp0,
    output group_regs_t grp1,
    output logic        sound_en
);

    logic       bus_wr;
    logic       data_wr;
    logic [4:0] addr_q;

    // per channel payload, channels 0-5
    logic [7:0] amp_q  [6];
    logic [8:0] freq_q [6];
    logic [2:0] oct_q  [6];

    logic [5:0] tone_en_q;
    logic [5:0] noise_en_q;
    logic [1:0] noise_sel0_q;
    logic [1:0] noise_sel1_q;
    logic [1:0] env_off_q;

    assign bus_wr  = !cs_n && !wr_n;
    assign data_wr = bus_wr && !a0;

    // address latch and control registers
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            addr_q       <= '0;
            tone_en_q    <= '0;
            noise_en_q   <= '0;
            noise_sel0_q <= '0;
            noise_sel1_q <= '0;
            env_off_q    <= '0;
            sound_en     <= 1'b0;
        end else if (bus_wr) begin
            if (a0) begin
                addr_q <= din[4:0];
            end else begin
                case (addr_q)
                    `SAA_ADDR_TONE_EN:  tone_en_q  <= din[5:0];
                    `SAA_ADDR_NOISE_EN: noise_en_q <= din[5:0];
                    `SAA_ADDR_NOISE_SEL: begin
                        noise_sel0_q <= din[1:0];
                        noise_sel1_q <= din[5:4];
                    end
                    `SAA_ADDR_ENV0:         env_off_q[0] <= din[7];
                    `SAA_ADDR_ENV0 + 5'd1:  env_off_q[1] <= din[7];
                    `SAA_ADDR_CTRL:         sound_en     <= din[0];
                    default: ;
                endcase
            end
        end
    end

    // amplitude, frequency and octave payload
    always_ff @(posedge clk) begin
        if (data_wr) begin
            for (int i = 0; i < 6; i++) begin
                if (addr_q == `SAA_ADDR_AMP0 + 5'(i)) begin
                    amp_q[i] <= din;
                end
                if (addr_q == `SAA_ADDR_FREQ0 + 5'(i)) begin
                    freq_q[i] <= 9'd510 - {1'b0, din};
                end
            end
            // octave pairs: low nibble even channel, high nibble odd channel
            for (int i = 0; i < 3; i++) begin
                if (addr_q == `SAA_ADDR_OCT0 + 5'(i)) begin
                    oct_q[2*i]   <= din[2:0];
                    oct_q[2*i+1] <= din[6:4];
                end
            end
        end
    end

    // split into the two group views
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            grp0.chan[i].amp     = amp_q[i];
            grp0.chan[i].freq    = freq_q[i];
            grp0.chan[i].octave  = oct_q[i];
            grp0.chan[i].tone_en = tone_en_q[i];
            grp1.chan[i].amp     = amp_q[i+3];
            grp1.chan[i].freq    = freq_q[i+3];
            grp1.chan[i].octave  = oct_q[i+3];
            grp1.chan[i].tone_en = tone_en_q[i+3];
        end
        grp0.noise_en     = noise_en_q[2:0];
        grp1.noise_en     = noise_en_q[5:3];
        grp0.noise_sel    = noise_sel0_q;
        grp1.noise_sel    = noise_sel1_q;
        grp0.env_tone_off = env_off_q[0];
        grp1.env_tone_off = env_off_q[1];
    end

    // an address cycle only moves the latch
    a_addr_wr_keeps_regs: assert property (@(posedge clk) disable iff (!rst_n)
        (bus_wr && a0) |=> (grp0 === $past(grp0)) && (grp1 === $past(grp1))
                           && (sound_en === $past(sound_en)));

endmodule

// File: rtl/saa_tone_gen.sv
module saa_tone_gen (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [2:0] octave,
    input  logic [8:0] freq,
    output logic       tone,
    output logic       period_pulse
);

    logic [7:0] presc_q;
    logic [8:0] fcnt_q;
    logic       presc_wrap;

    assign presc_wrap   = (presc_q == 8'd0);
    assign period_pulse = presc_wrap && (fcnt_q == freq);

    // octave prescaler, divides by 2^(8 - octave)
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            presc_q <= '0;
        end else if (presc_wrap) begin
            presc_q <= 8'hff >> octave;
        end else begin
            presc_q <= presc_q - 8'd1;
        end
    end

    // frequency counter runs on prescaler wraps
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            fcnt_q <= '0;
            tone   <= 1'b0;
        end else if (presc_wrap) begin
            if (fcnt_q == freq) begin
                fcnt_q <= '0;
                tone   <= ~tone;
            end else begin
                fcnt_q <= fcnt_q + 9'd1;
            end
        end
    end

    // a period ends only on a wrap, and the tone flips right after it
    a_pulse_on_wrap: assert property (@(posedge clk) disable iff (!rst_n)
        period_pulse |=> $past(presc_wrap) && (tone != $past(tone)));

endmodule

// File: rtl/saa_noise_gen.sv
`include "saa_params.svh"

module saa_noise_gen (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [1:0] noise_sel,
    input  logic       tone_pulse,
    output logic       noise
);

    logic [9:0]  rate_cnt_q;
    logic [9:0]  rate_last;
    logic        rate_wrap;
    logic        step;
    logic [30:0] lfsr_q;

    // last count of the fixed rate divider
    always_comb begin
        case (noise_sel)
            2'd0:    rate_last = 10'(`SAA_NOISE_PERIOD0 - 1);
            2'd1:    rate_last = 10'(`SAA_NOISE_PERIOD1 - 1);
            default: rate_last = 10'(`SAA_NOISE_PERIOD2 - 1);
        endcase
    end

    // >= so a slower-to-faster switch wraps at once
    assign rate_wrap = (rate_cnt_q >= rate_last);
    assign step      = (noise_sel == 2'd3) ? tone_pulse : rate_wrap;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rate_cnt_q <= '0;
        end else if (rate_wrap) begin
            rate_cnt_q <= '0;
        end else begin
            rate_cnt_q <= rate_cnt_q + 10'd1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // 31-bit LFSR, taps 2 and 30
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lfsr_q <= `SAA_LFSR_SEED;
        end else if (step) begin
            lfsr_q <= {lfsr_q[29:0], lfsr_q[2] ^ lfsr_q[30]};
        end
    end

    assign noise = lfsr_q[0];

endmodule

// File: rtl/saa_voice_group.sv
module saa_voice_group import saa_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  group_regs_t   regs,
    output group_levels_t levels
);

    logic [2:0]    tone;
    logic [2:0]    tone_on;
    logic          tone0_pulse;
    logic          noise;
    group_levels_t next_levels;

    ////////////////////////////////////////////////////////////////////////////
    // generators
    ////////////////////////////////////////////////////////////////////////////

    // channel 0 also clocks the noise source
    saa_tone_gen u_tone0 (
        .clk          (clk),
        .rst_n        (rst_n),
        .octave       (regs.chan[0].octave),
        .freq         (regs.chan[0].freq),
        .tone         (tone[0]),
        .period_pulse (tone0_pulse)
    );

    saa_tone_gen u_tone1 (
        .clk          (clk),
        .rst_n        (rst_n),
        .octave       (regs.chan[1].octave),
        .freq         (regs.chan[1].freq),
        .tone         (tone[1]),
        .period_pulse ()
    );

    saa_tone_gen u_tone2 (
        .clk          (clk),
        .rst_n        (rst_n),
        .octave       (regs.chan[2].octave),
        .freq         (regs.chan[2].freq),
        .tone         (tone[2]),
        .period_pulse ()
    );

    saa_noise_gen u_noise (
        .clk        (clk),
        .rst_n      (rst_n),
        .noise_sel  (regs.noise_sel),
        .tone_pulse (tone0_pulse),
        .noise      (noise)
    );

    ////////////////////////////////////////////////////////////////////////////
    // channel mixers
    ////////////////////////////////////////////////////////////////////////////

    // channel 0 is busy clocking noise, channel 1 yields to the envelope bit
    assign tone_on[0] = regs.chan[0].tone_en && (regs.noise_sel != 2'd3);
    assign tone_on[1] = regs.chan[1].tone_en && !regs.env_tone_off;
    assign tone_on[2] = regs.chan[2].tone_en;

    always_comb begin
        for (int i = 0; i < 3; i++) begin
            next_levels[i] = '0;
            if (tone_on[i] && tone[i]) begin
                next_levels[i].left  = next_levels[i].left + {1'b0, regs.chan[i].amp[3:0]};
                next_levels[i].right = next_levels[i].right + {1'b0, regs.chan[i].amp[7:4]};
            end
            if (regs.noise_en[i] && noise) begin
                next_levels[i].left  = next_levels[i].left + {1'b0, regs.chan[i].amp[3:0]};
                next_levels[i].right = next_levels[i].right + {1'b0, regs.chan[i].amp[7:4]};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            levels <= '0;
        end else begin
            levels <= next_levels;
        end
    end

endmodule

// File: rtl/saa_output_mixer.sv
module saa_output_mixer import saa_pkg::*; (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          sound_en,
    input  group_levels_t levels0,
    input  group_levels_t levels1,
    output logic [7:0]    out_l,
    output logic [7:0]    out_r
);

    logic [7:0] sum_l;
    logic [7:0] sum_r;

    // six levels of at most 30 each, fits 8 bits
    always_comb begin
        sum_l = '0;
        sum_r = '0;
        for (int i = 0; i < 3; i++) begin
            sum_l = sum_l + 8'(levels0[i].left) + 8'(levels1[i].left);
            sum_r = sum_r + 8'(levels0[i].right) + 8'(levels1[i].right);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_l <= '0;
            out_r <= '0;
        end else if (sound_en) begin
            out_l <= sum_l;
            out_r <= sum_r;
        end else begin
            out_l <= '0;
            out_r <= '0;
        end
    end

    // muted chip goes silent on the next sample
    a_mute: assert property (@(posedge clk) disable iff (!rst_n)
        !sound_en |=> (out_l == 8'd0) && (out_r == 8'd0));

endmodule

// File: rtl/saa_sound_top.sv
module saa_sound_top import saa_pkg::*; (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       cs_n,
    input  logic       a0,
    input  logic       wr_n,
    input  logic [7:0] din,
    output logic [7:0] out_l,
    output logic [7:0] out_r
);

    group_regs_t   grp0;
    group_regs_t   grp1;
    logic          sound_en;
    group_levels_t levels0;
    group_levels_t levels1;

    saa_reg_file u_reg_file (
        .clk      (clk),
        .rst_n    (rst_n),
        .cs_n     (cs_n),
        .a0       (a0),
        .wr_n     (wr_n),
        .din      (din),
        .grp0     (grp0),
        .grp1     (grp1),
        .sound_en (sound_en)
    );

    // channels 0-2
    saa_voice_group u_group0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .regs   (grp0),
        .levels (levels0)
    );

    // channels 3-5
    saa_voice_group u_group1 (
        .clk    (clk),
        .rst_n  (rst_n),
        .regs   (grp1),
        .levels (levels1)
    );

    saa_output_mixer u_output_mixer (
        .clk      (clk),
        .rst_n    (rst_n),
        .sound_en (sound_en),
        .levels0  (levels0),
        .levels1  (levels1),
        .out_l    (out_l),
        .out_r    (out_r)
    );

endmodule

// File: testbench/tb_saa_sound.sv
`include "saa_params.svh"

module tb_saa_sound;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 40000;
    localparam int MODE_OFF       = 0;
    // any mix of the enabled tones, noise off
    localparam int MODE_TONES     = 1;
    // exact compare against the reference noise source
    localparam int MODE_NOISE     = 2;

    logic       clk = 1'b0;
    logic       rst_n;
    logic       cs_n;
    logic       a0;
    logic       wr_n;
    logic [7:0] din;
    logic [7:0] out_l;
    logic [7:0] out_r;

    // shadow copy of the register map
    logic [7:0] amp_sh [6];
    logic [5:0] tone_en_sh;
    logic [5:0] noise_en_sh;
    logic [7:0] noise_sel_sh;
    logic [1:0] env_sh;
    logic       sound_en_sh;

    logic [30:0] ref_lfsr;
    int          step_cnt;
    logic        noise_d1;
    logic        noise_d2;

    int   mode = MODE_OFF;
    int   cycle_cnt = 0;
    int   check_cnt = 0;
    int   err_cnt = 0;
    int   seed = 32'hdd1f_dcf0;
    logic mix_found;

    saa_sound_top uut (
        .clk   (clk),
        .rst_n (rst_n),
        .cs_n  (cs_n),
        .a0    (a0),
        .wr_n  (wr_n),
        .din   (din),
        .out_l (out_l),
        .out_r (out_r)
    );

    always #50 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    // clocks per tone half-period, divisor times (510 - din + 1)
    function automatic int half_period(input logic [7:0] d, input logic [2:0] oct);
        return (1 << (8 - int'(oct))) * (511 - int'(d));
    endfunction

    function automatic logic [30:0] lfsr_next(input logic [30:0] s);
        return {s[29:0], s[2] ^ s[30]};
    endfunction

    function automatic logic tone_muted(input int ch);
        case (ch)
            0:       return noise_sel_sh[1:0] == 2'd3;
            3:       return noise_sel_sh[5:4] == 2'd3;
            1:       return env_sh[0];
            4:       return env_sh[1];
            default: return 1'b0;
        endcase
    endfunction

    // one side's sample for given tone states and per-group noise bits
    function automatic logic [7:0] ref_sample(input logic [5:0] tones,
                                              input logic [1:0] noises,
                                              input logic       right);
        int sum;
        int nib;
        int hits;
        sum = 0;
        for (int i = 0; i < 6; i++) begin
            nib  = right ? int'(amp_sh[i][7:4]) : int'(amp_sh[i][3:0]);
            hits = 0;
            if (tone_en_sh[i] && tones[i] && !tone_muted(i)) hits = hits + 1;
            if (noise_en_sh[i] && noises[i / 3]) hits = hits + 1;
            sum = sum + nib * hits;
        end
        if (!sound_en_sh) sum = 0;
        return 8'(sum);
    endfunction

    // nonzero so a tone always shows up
    function automatic logic [3:0] rand_nibble();
        return 4'(($unsigned($random(seed)) % 15) + 1);
    endfunction

    // group 1 noise source at rate 0, delayed by level and output registers
    always @(posedge clk) begin
        if (!rst_n) begin
            ref_lfsr <= `SAA_LFSR_SEED;
            step_cnt <= 0;
            noise_d1 <= 1'b0;
            noise_d2 <= 1'b0;
        end else begin
            if (step_cnt == `SAA_NOISE_PERIOD0 - 1) begin
                ref_lfsr <= lfsr_next(ref_lfsr);
                step_cnt <= 0;
            end else begin
                step_cnt <= step_cnt + 1;
            end
            noise_d1 <= ref_lfsr[0];
            noise_d2 <= noise_d1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [7:0] got,
                               input logic [7:0] exp);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("[ERROR] %0t %s: got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    always @(negedge clk) begin
        if (mode == MODE_TONES) begin
            mix_found = 1'b0;
            for (int t = 0; t < 64; t++) begin
                if (out_l == ref_sample(6'(t), 2'b00, 1'b0)
                    && out_r == ref_sample(6'(t), 2'b00, 1'b1)) begin
                    mix_found = 1'b1;
                end
            end
            check_cnt++;
            if (!mix_found) begin
                err_cnt++;
                $display("[ERROR] %0t out_l/out_r: got %0d/%0d, which no tone mix gives",
                         $time, out_l, out_r);
            end
        end else if (mode == MODE_NOISE) begin
            check_value("out_l", out_l, ref_sample(6'b0, {noise_d2, 1'b0}, 1'b0));
            check_value("out_r", out_r, ref_sample(6'b0, {noise_d2, 1'b0}, 1'b1));
        end
    end

    // watchdog
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // bus and stimulus
    ////////////////////////////////////////////////////////////////////////////

    // address cycle, data cycle, then idle; returns on the data edge
    task automatic write_reg(input logic [4:0] addr, input logic [7:0] data);
        @(posedge clk);
        cs_n <= 1'b0;
        wr_n <= 1'b0;
        a0   <= 1'b1;
        din  <= {3'b000, addr};
        @(posedge clk);
        a0  <= 1'b0;
        din <= data;
        @(posedge clk);
        cs_n <= 1'b1;
        wr_n <= 1'b1;
        din  <= 8'h00;
        for (int i = 0; i < 6; i++) begin
            if (addr == `SAA_ADDR_AMP0 + 5'(i)) amp_sh[i] = data;
        end
        if (addr == `SAA_ADDR_TONE_EN) tone_en_sh = data[5:0];
        if (addr == `SAA_ADDR_NOISE_EN) noise_en_sh = data[5:0];
        if (addr == `SAA_ADDR_NOISE_SEL) noise_sel_sh = data;
        if (addr == `SAA_ADDR_ENV0) env_sh[0] = data[7];
        if (addr == `SAA_ADDR_ENV0 + 5'd1) env_sh[1] = data[7];
        if (addr == `SAA_ADDR_CTRL) sound_en_sh = data[0];
    endtask

    // output must flip between zero and the channel's nibbles, half apart
    task automatic check_alternation(input int ch, input int half);
        logic [7:0] hi_l;
        logic [7:0] hi_r;
        logic [7:0] prev_l;
        logic [7:0] prev_r;
        int         last;
        int         edges;
        hi_l  = ref_sample(6'(1 << ch), 2'b00, 1'b0);
        hi_r  = ref_sample(6'(1 << ch), 2'b00, 1'b1);
        edges = 0;
        @(negedge clk);
        prev_l = out_l;
        prev_r = out_r;
        last   = cycle_cnt;
        while (edges < 4) begin
            @(negedge clk);
            if (out_l != prev_l || out_r != prev_r) begin
                check_value("out_l", out_l, (prev_l == 8'd0) ? hi_l : 8'd0);
                check_value("out_r", out_r, (prev_l == 8'd0) ? hi_r : 8'd0);
                if (edges > 0) begin
                    check_cnt++;
                    if (cycle_cnt - last != half) begin
                        err_cnt++;
                        $display("[ERROR] %0t tone half-period: got %0d expected %0d",
                                 $time, cycle_cnt - last, half);
                    end
                end
                last   = cycle_cnt;
                prev_l = out_l;
                prev_r = out_r;
                edges++;
            end else if (cycle_cnt - last > half) begin
                err_cnt++;
                $display("%0t channel %0d: tone stopped, no change within %0d cycles",
                         $time, ch, half);
                edges = 4;
            end
        end
    endtask

    initial begin : stimulus
        logic [3:0] l0;
        logic [3:0] r0;
        logic [3:0] l3;
        logic [3:0] r3;
        int         half;
        rst_n        = 1'b0;
        cs_n         = 1'b1;
        wr_n         = 1'b1;
        a0           = 1'b0;
        din          = 8'h00;
        tone_en_sh   = '0;
        noise_en_sh  = '0;
        noise_sel_sh = '0;
        env_sh       = '0;
        sound_en_sh  = 1'b0;
        for (int i = 0; i < 6; i++) amp_sh[i] = 8'h00;
        half = half_period(8'd250, 3'd7);
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        mode = MODE_TONES;

        // silent after reset, and with a channel set up while sound is off
        for (int i = 0; i < 3; i++) write_reg(`SAA_ADDR_OCT0 + 5'(i), 8'h77);
        for (int i = 0; i < 6; i++) write_reg(`SAA_ADDR_FREQ0 + 5'(i), 8'd250);
        for (int i = 0; i < 6; i++) write_reg(`SAA_ADDR_AMP0 + 5'(i), 8'h00);
        l0 = rand_nibble();
        r0 = rand_nibble();
        write_reg(`SAA_ADDR_AMP0, {r0, l0});
        write_reg(`SAA_ADDR_TONE_EN, 8'h01);
        repeat (1500) @(posedge clk);

        // single tone, octave 7, din 250
        mode = MODE_OFF;
        write_reg(`SAA_ADDR_CTRL, 8'h01);
        repeat (3) @(posedge clk);
        mode = MODE_TONES;
        check_alternation(0, half);

        // same tone on channels 0 and 3, distinct nibbles
        mode = MODE_OFF;
        l0 = rand_nibble();
        do r0 = rand_nibble(); while (r0 == l0);
        do l3 = rand_nibble(); while (l3 == l0 || l3 == r0);
        do r3 = rand_nibble(); while (r3 == l0 || r3 == r0 || r3 == l3);
        write_reg(`SAA_ADDR_AMP0, {r0, l0});
        write_reg(`SAA_ADDR_AMP0 + 5'd3, {r3, l3});
        write_reg(`SAA_ADDR_TONE_EN, 8'h09);
        repeat (3) @(posedge clk);
        mode = MODE_TONES;
        repeat (3000) @(posedge clk);

        // channel 0 muted while it clocks the noise source
        mode = MODE_OFF;
        write_reg(`SAA_ADDR_TONE_EN, 8'h01);
        write_reg(`SAA_ADDR_NOISE_SEL, 8'h03);
        repeat (3) @(posedge clk);
        mode = MODE_TONES;
        repeat (1200) @(posedge clk);
        mode = MODE_OFF;
        write_reg(`SAA_ADDR_NOISE_SEL, 8'h00);
        repeat (3) @(posedge clk);
        mode = MODE_TONES;
        check_alternation(0, half);

        // channel 1 muted by envelope bit 7
        mode = MODE_OFF;
        write_reg(`SAA_ADDR_AMP0 + 5'd1, {rand_nibble(), rand_nibble()});
        write_reg(`SAA_ADDR_TONE_EN, 8'h02);
        write_reg(`SAA_ADDR_ENV0, 8'h80);
        repeat (3) @(posedge clk);
        mode = MODE_TONES;
        repeat (1200) @(posedge clk);
        mode = MODE_OFF;
        write_reg(`SAA_ADDR_ENV0, 8'h00);
        repeat (3) @(posedge clk);
        mode = MODE_TONES;
        check_alternation(1, half);

        // noise only on channel 3, fixed rate 0
        mode = MODE_OFF;
        write_reg(`SAA_ADDR_TONE_EN, 8'h00);
        write_reg(`SAA_ADDR_NOISE_EN, 8'h08);
        repeat (3) @(posedge clk);
        mode = MODE_NOISE;
        repeat (5000) @(posedge clk);

        // sound off, silent from the second edge after the write
        mode = MODE_OFF;
        write_reg(`SAA_ADDR_CTRL, 8'h00);
        @(posedge clk);
        mode = MODE_TONES;
        repeat (1500) @(posedge clk);

        mode = MODE_OFF;
        $display("checks: %0d  errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+rtl
rtl/saa_pkg.sv
rtl/saa_reg_file.sv
rtl/saa_tone_gen.sv
rtl/saa_noise_gen.sv
rtl/saa_voice_group.sv
rtl/saa_output_mixer.sv
rtl/saa_sound_top.sv
testbench/tb_saa_sound.sv

// File: Makefile
SRCS := $(wildcard rtl/*.sv rtl/*.svh testbench/*.sv)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
obj_dir/Vtb_saa_sound: list.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/1ps -f list.f \
		--top-module tb_saa_sound -o Vtb_saa_sound

run: obj_dir/Vtb_saa_sound
	./obj_dir/Vtb_saa_sound | tee sim.log
	grep -qx "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
